/* include/dfe_config.svh */
`ifndef DFE_CONFIG_SVH
`define DFE_CONFIG_SVH

// number of post-cursor taps, one per past decision
`define DFE_NUM_TAPS 4

// signed input sample and signed tap coefficient widths
`define DFE_SAMPLE_W 8
`define DFE_TAP_W 8

// main-cursor gain is a power of two, stored as its exponent
`define DFE_SHIFT_W 3

// partial sums and the scaled sample share this width
`define DFE_ACC_W 20
`define DFE_EQ_W 16
`define DFE_IDX_W 2

`endif

/* logic/dfe_pkg.sv */
`include "dfe_config.svh"

package dfe_pkg;

    // controller states
    typedef enum logic [1:0] {
        LOAD  = 2'd0,
        RUN   = 2'd1,
        CLEAR = 2'd2
    } dfe_state_e;

    // configuration port opcodes
    typedef enum logic [1:0] {
        OP_WRITE_TAP   = 2'd0,
        OP_WRITE_SHIFT = 2'd1,
        OP_START       = 2'd2,
        OP_CLEAR       = 2'd3
    } cfg_op_e;

    typedef logic signed [`DFE_SAMPLE_W-1:0] sample_t;
    typedef logic signed [`DFE_TAP_W-1:0]    tap_t;
    typedef logic signed [`DFE_EQ_W-1:0]     eq_t;

    // 1 stands for +1 and 0 for -1
    typedef logic decision_t;

endpackage

/* logic/dfe_coef_if.sv */
`timescale 1ns/1ps
`include "dfe_config.svh"

interface dfe_coef_if;

    // post-cursor taps, entry k weights the decision k+1 symbols back
    dfe_pkg::tap_t [`DFE_NUM_TAPS-1:0] taps;
    logic [`DFE_SHIFT_W-1:0]           cursor_shift;

    // run enables sample acceptance, flush empties the history for one cycle
    logic run;
    logic flush;

    // the tap bank and the controller each drive their own share of the source side
    modport source (
        output taps,
        output cursor_shift,
        output run,
        output flush
    );

    modport sink (
        input taps,
        input cursor_shift,
        input run,
        input flush
    );

endinterface

/* logic/dfe_ctrl.sv */
`timescale 1ns/1ps

module dfe_ctrl (
    input  logic              clk,
    input  logic              rstn,
    input  logic              cfg_valid,
    input  dfe_pkg::cfg_op_e  cfg_op,
    input  logic              full,
    output logic              cfg_ready,
    output logic              cfg_err,
    output logic              loaded,
    output logic              load_en,
    output logic              count_clear,
    dfe_coef_if.source        coef
);

    dfe_pkg::dfe_state_e state;
    dfe_pkg::dfe_state_e state_next;
    logic                accept;
    logic                start_cmd;
    logic                clear_cmd;

    // commands are refused only during the single flush cycle
    assign cfg_ready = (state != dfe_pkg::CLEAR);
    assign accept    = cfg_valid & cfg_ready;

    assign start_cmd = accept & (cfg_op == dfe_pkg::OP_START);
    assign clear_cmd = accept & (cfg_op == dfe_pkg::OP_CLEAR);

    // coefficient writes go through in LOAD and in RUN alike
    assign load_en = accept & ((cfg_op == dfe_pkg::OP_WRITE_TAP) |
                               (cfg_op == dfe_pkg::OP_WRITE_SHIFT));

    always_comb begin
        state_next = state;
        case (state)
            dfe_pkg::LOAD: begin
                // a start before the full set is written keeps us here
                if (clear_cmd) begin
                    state_next = dfe_pkg::CLEAR;
                end else if (start_cmd && full) begin
                    state_next = dfe_pkg::RUN;
                end
            end
            dfe_pkg::RUN: begin
                if (clear_cmd) begin
                    state_next = dfe_pkg::CLEAR;
                end
            end
            dfe_pkg::CLEAR: begin
                // flush lasts one cycle, then taps must be loaded again
                state_next = dfe_pkg::LOAD;
            end
            default: begin
                state_next = dfe_pkg::LOAD;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= dfe_pkg::LOAD;
            cfg_err <= 1'b0;
        end else begin
            state   <= state_next;
            // one-cycle error pulse for a premature start
            cfg_err <= start_cmd & ~full & (state == dfe_pkg::LOAD);
        end
    end

    // flush and the counter clear both come straight from the CLEAR state
    assign count_clear = (state == dfe_pkg::CLEAR);
    assign loaded      = (state == dfe_pkg::RUN);
    assign coef.run    = (state == dfe_pkg::RUN);
    assign coef.flush  = (state == dfe_pkg::CLEAR);

endmodule

/* logic/tap_load_counter.sv */
`timescale 1ns/1ps
`include "dfe_config.svh"

module tap_load_counter (
    input  logic clk,
    input  logic rstn,
    input  logic count_en,
    input  logic count_clear,
    output logic full
);

    // one write per tap plus one for the cursor shift
    localparam int unsigned FULL_COUNT = `DFE_NUM_TAPS + 1;
    localparam int unsigned CNT_W      = $clog2(FULL_COUNT + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count <= '0;
        end else if (count_clear) begin
            count <= '0;
        end else if (count_en && !full) begin
            // saturates at the full value, extra writes just update taps
            count <= count + CNT_W'(1);
        end
    end

    // counts writes, not distinct entries, so a repeated index still counts
    assign full = (count == CNT_W'(FULL_COUNT));

endmodule

/* logic/tap_bank.sv */
`timescale 1ns/1ps
`include "dfe_config.svh"

module tap_bank (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    wr_en,
    input  logic                    wr_shift,
    input  logic                    clear,
    input  logic [`DFE_IDX_W-1:0]   cfg_index,
    input  dfe_pkg::tap_t           cfg_data,
    dfe_coef_if.source              coef
);

    dfe_pkg::tap_t [`DFE_NUM_TAPS-1:0] taps_q;
    logic [`DFE_SHIFT_W-1:0]           shift_q;

    // tap registers, indexed by the configuration port
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            taps_q <= '0;
        end else if (clear) begin
            // zero taps mean no ISI correction until reloaded
            taps_q <= '0;
        end else if (wr_en && !wr_shift) begin
            taps_q[cfg_index] <= cfg_data;
        end
    end

    // main-cursor shift takes only the low bits of the data word
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            shift_q <= '0;
        end else if (clear) begin
            shift_q <= '0;
        end else if (wr_en && wr_shift) begin
            shift_q <= cfg_data[`DFE_SHIFT_W-1:0];
        end
    end

    // new values reach the datapath one cycle after the write is accepted
    assign coef.taps         = taps_q;
    assign coef.cursor_shift = shift_q;

endmodule

/* logic/dfe_datapath.sv */
`timescale 1ns/1ps
`include "dfe_config.svh"

module dfe_datapath (
    input  logic                clk,
    input  logic                rstn,
    dfe_coef_if.sink            coef,
    input  logic                in_valid,
    output logic                in_ready,
    input  dfe_pkg::sample_t    in_sample,
    output logic                out_valid,
    input  logic                out_ready,
    output dfe_pkg::eq_t        out_eq,
    output dfe_pkg::decision_t  out_decision
);

    localparam int N = `DFE_NUM_TAPS;

    // psum[0] is the full ISI for the next sample, psum[N-1] holds only the newest term
    logic signed [`DFE_ACC_W-1:0] psum      [N];
    logic signed [`DFE_ACC_W-1:0] psum_next [N];
    logic signed [`DFE_ACC_W-1:0] term      [N];

    logic signed [`DFE_ACC_W-1:0] sample_ext;
    logic signed [`DFE_ACC_W-1:0] sample_scaled;
    logic signed [`DFE_ACC_W-1:0] scaled;
    logic signed [`DFE_ACC_W-1:0] eq_full;
    dfe_pkg::decision_t           decision;
    logic                         accept;

    // accept only when the output register is empty or being drained
    assign in_ready = coef.run & (~out_valid | out_ready);
    assign accept   = in_valid & in_ready;

    // sign extend the sample, then apply the main-cursor gain
    assign sample_ext    = {{(`DFE_ACC_W-`DFE_SAMPLE_W){in_sample[`DFE_SAMPLE_W-1]}}, in_sample};
    assign sample_scaled = sample_ext <<< coef.cursor_shift;

    // the loop closes here, the decision feeds the chain in the same cycle
    assign scaled   = sample_scaled - psum[0];
    assign decision = ~scaled[`DFE_ACC_W-1];

    // undo the cursor gain so the output sits on the sample scale
    assign eq_full = scaled >>> coef.cursor_shift;

    // each tap adds or subtracts itself, depending on the sign of the new decision
    always_comb begin
        logic signed [`DFE_ACC_W-1:0] tap_ext;
        for (int i = 0; i < N; i++) begin
            tap_ext = {{(`DFE_ACC_W-`DFE_TAP_W){coef.taps[i][`DFE_TAP_W-1]}}, coef.taps[i]};
            term[i] = decision ? tap_ext : -tap_ext;
        end
    end

    // transposed chain, every stage takes its upstream neighbour plus its own term
    always_comb begin
        for (int i = 0; i < N - 1; i++) begin
            psum_next[i] = psum[i+1] + term[i];
        end
        psum_next[N-1] = term[N-1];
    end

    // history only moves on accepted samples, flush empties it
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < N; i++) begin
                psum[i] <= '0;
            end
        end else if (coef.flush) begin
            for (int i = 0; i < N; i++) begin
                psum[i] <= '0;
            end
        end else if (accept) begin
            for (int i = 0; i < N; i++) begin
                psum[i] <= psum_next[i];
            end
        end
    end

    // output valid, held until the consumer takes it
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else if (coef.flush) begin
            out_valid <= 1'b0;
        end else if (accept) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // result payload, loaded on acceptance and zeroed by a flush
    always_ff @(posedge clk) begin
        if (coef.flush) begin
            out_eq       <= '0;
            out_decision <= 1'b0;
        end else if (accept) begin
            out_eq       <= eq_full[`DFE_EQ_W-1:0];
            out_decision <= decision;
        end
    end

endmodule

/* logic/dfe_top.sv */
`timescale 1ns/1ps
`include "dfe_config.svh"

module dfe_top (
    input  logic                    clk,
    input  logic                    rstn,
    // configuration port
    input  logic                    cfg_valid,
    output logic                    cfg_ready,
    input  dfe_pkg::cfg_op_e        cfg_op,
    input  logic [`DFE_IDX_W-1:0]   cfg_index,
    input  dfe_pkg::tap_t           cfg_data,
    output logic                    cfg_err,
    output logic                    loaded,
    // sample stream in
    input  logic                    in_valid,
    output logic                    in_ready,
    input  dfe_pkg::sample_t        in_sample,
    // equalized stream out
    output logic                    out_valid,
    input  logic                    out_ready,
    output dfe_pkg::eq_t            out_eq,
    output dfe_pkg::decision_t      out_decision
);

    logic load_en;
    logic count_clear;
    logic full;
    logic wr_shift;

    // coefficients and run control from the control side to the datapath
    dfe_coef_if coef ();

    // the opcode picks between tap and shift on an accepted write
    assign wr_shift = (cfg_op == dfe_pkg::OP_WRITE_SHIFT);

    dfe_ctrl u_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .cfg_valid   (cfg_valid),
        .cfg_op      (cfg_op),
        .full        (full),
        .cfg_ready   (cfg_ready),
        .cfg_err     (cfg_err),
        .loaded      (loaded),
        .load_en     (load_en),
        .count_clear (count_clear),
        .coef        (coef.source)
    );

    tap_load_counter u_counter (
        .clk         (clk),
        .rstn        (rstn),
        .count_en    (load_en),
        .count_clear (count_clear),
        .full        (full)
    );

    // the bank is cleared in the same cycle as the counter
    tap_bank u_bank (
        .clk       (clk),
        .rstn      (rstn),
        .wr_en     (load_en),
        .wr_shift  (wr_shift),
        .clear     (count_clear),
        .cfg_index (cfg_index),
        .cfg_data  (cfg_data),
        .coef      (coef.source)
    );

    dfe_datapath u_datapath (
        .clk          (clk),
        .rstn         (rstn),
        .coef         (coef.sink),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_sample    (in_sample),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_eq       (out_eq),
        .out_decision (out_decision)
    );

endmodule

/* verif/dfe_tb.sv */
`timescale 1ns/1ps
`include "dfe_config.svh"

module dfe_tb;

    localparam int N_TAPS      = `DFE_NUM_TAPS;
    localparam int ZERO_LEN    = 8;
    localparam int RAND_LEN    = 40;
    localparam int TABLE_LEN   = ZERO_LEN + RAND_LEN;
    localparam int CFG_TIMEOUT = 20;
    localparam int RUN_TIMEOUT = 1000;
    localparam logic [31:0] LFSR_SEED = 32'ha519_828c;

    logic                    clk;
    logic                    rstn;
    logic                    cfg_valid;
    logic                    cfg_ready;
    dfe_pkg::cfg_op_e        cfg_op;
    logic [`DFE_IDX_W-1:0]   cfg_index;
    dfe_pkg::tap_t           cfg_data;
    logic                    cfg_err;
    logic                    loaded;
    logic                    in_valid;
    logic                    in_ready;
    dfe_pkg::sample_t        in_sample;
    logic                    out_valid;
    logic                    out_ready;
    dfe_pkg::eq_t            out_eq;
    dfe_pkg::decision_t      out_decision;

    // the first table section runs with random taps and the second with zero taps
    dfe_pkg::sample_t        sample_tab  [TABLE_LEN];
    dfe_pkg::eq_t            exp_eq_tab  [TABLE_LEN];
    dfe_pkg::decision_t      exp_dec_tab [TABLE_LEN];
    dfe_pkg::tap_t [N_TAPS-1:0] zero_taps;
    dfe_pkg::tap_t [N_TAPS-1:0] rand_taps;
    logic [`DFE_SHIFT_W-1:0] zero_shift;
    logic [`DFE_SHIFT_W-1:0] rand_shift;
    logic [31:0]             lfsr;

    dfe_top uut (
        .clk          (clk),
        .rstn         (rstn),
        .cfg_valid    (cfg_valid),
        .cfg_ready    (cfg_ready),
        .cfg_op       (cfg_op),
        .cfg_index    (cfg_index),
        .cfg_data     (cfg_data),
        .cfg_err      (cfg_err),
        .loaded       (loaded),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_sample    (in_sample),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_eq       (out_eq),
        .out_decision (out_decision)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // takes n bits with one LFSR step per bit and the newest bit lands in bit 0
    task automatic get_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic check_eq(input string name, input dfe_pkg::eq_t got, input dfe_pkg::eq_t exp);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_decision(input string name, input dfe_pkg::decision_t got,
                                  input dfe_pkg::decision_t exp);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %0b, expected %0b", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %0b, expected %0b", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout at time %0t while waiting for %s", $time, what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    // the sample times the cursor gain minus the predicted ISI
    function automatic int scaled_value(input int sample, input int isi, input int shift);
        return (sample * (1 << shift)) - isi;
    endfunction

    // reference model of the equalizer over one section that starts with empty history
    task automatic fill_table(input int first, input int count,
                              input dfe_pkg::tap_t [N_TAPS-1:0] taps,
                              input logic [`DFE_SHIFT_W-1:0] shift);
        int hist [N_TAPS];
        int isi;
        int scaled;
        for (int k = 0; k < N_TAPS; k++) begin
            hist[k] = 0;
        end
        for (int n = first; n < first + count; n++) begin
            isi = 0;
            // hist[k] holds the decision k+1 symbols back and stays zero until one exists
            for (int k = 0; k < N_TAPS; k++) begin
                isi = isi + int'(taps[k]) * hist[k];
            end
            scaled = scaled_value(int'(sample_tab[n]), isi, int'(shift));
            exp_eq_tab[n]  = dfe_pkg::eq_t'(scaled >>> int'(shift));
            exp_dec_tab[n] = (scaled >= 0);
            for (int k = N_TAPS - 1; k > 0; k--) begin
                hist[k] = hist[k-1];
            end
            hist[0] = (scaled >= 0) ? 1 : -1;
        end
    endtask

    // holds one command on the port until it is accepted
    task automatic send_cmd(input dfe_pkg::cfg_op_e op, input logic [`DFE_IDX_W-1:0] idx,
                            input dfe_pkg::tap_t data);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        cfg_valid = 1'b1;
        cfg_op    = op;
        cfg_index = idx;
        cfg_data  = data;
        @(negedge clk);
        while (!cfg_ready) begin
            cycles++;
            if (cycles > CFG_TIMEOUT) begin
                stop_on_timeout("cfg_ready");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        cfg_valid = 1'b0;
    endtask

    task automatic load_coefs(input dfe_pkg::tap_t [N_TAPS-1:0] taps,
                              input logic [`DFE_SHIFT_W-1:0] shift);
        for (int k = 0; k < N_TAPS; k++) begin
            send_cmd(dfe_pkg::OP_WRITE_TAP, `DFE_IDX_W'(k), taps[k]);
        end
        send_cmd(dfe_pkg::OP_WRITE_SHIFT, '0, dfe_pkg::tap_t'(shift));
    endtask

    // a refused start gives a single-cycle error and stays out of RUN
    task automatic expect_start_error();
        @(negedge clk);
        check_flag("cfg_err", cfg_err, 1'b1);
        check_flag("loaded", loaded, 1'b0);
        @(negedge clk);
        check_flag("cfg_err", cfg_err, 1'b0);
        check_flag("loaded", loaded, 1'b0);
    endtask

    task automatic expect_start_ok();
        @(negedge clk);
        check_flag("cfg_err", cfg_err, 1'b0);
        check_flag("loaded", loaded, 1'b1);
        check_flag("in_ready", in_ready, 1'b1);
    endtask

    // streams one table section through the DUT with random back-pressure
    task automatic run_section(input int first, input int count);
        int in_idx;
        int out_idx;
        int cycles;
        logic in_hs;
        logic out_hs;
        logic held;
        dfe_pkg::eq_t held_eq;
        dfe_pkg::decision_t held_dec;
        logic [31:0] r;
        in_idx  = first;
        out_idx = first;
        cycles  = 0;
        held    = 1'b0;
        @(posedge clk);
        #1;
        in_valid  = 1'b1;
        in_sample = sample_tab[first];
        out_ready = 1'b1;
        while (out_idx < first + count) begin
            // handshakes are judged mid-cycle where every signal is settled
            @(negedge clk);
            if (held) begin
                check_flag("out_valid", out_valid, 1'b1);
                check_eq("out_eq", out_eq, held_eq);
                check_decision("out_decision", out_decision, held_dec);
            end
            in_hs  = in_valid & in_ready;
            out_hs = out_valid & out_ready;
            held   = out_valid & ~out_ready;
            held_eq  = out_eq;
            held_dec = out_decision;
            // a stalled output must also stall the input
            if (held) begin
                check_flag("in_ready", in_ready, 1'b0);
            end
            if (out_hs) begin
                check_eq("out_eq", out_eq, exp_eq_tab[out_idx]);
                check_decision("out_decision", out_decision, exp_dec_tab[out_idx]);
                out_idx++;
            end
            cycles++;
            if (cycles > RUN_TIMEOUT) begin
                stop_on_timeout("the equalized results");
            end
            @(posedge clk);
            #1;
            if (in_hs) begin
                in_idx++;
            end
            in_valid = (in_idx < first + count);
            if (in_valid) begin
                in_sample = sample_tab[in_idx];
            end
            // out_ready drops on about one cycle in four
            get_bits(2, r);
            out_ready = (r[1:0] != 2'b00);
        end
        @(negedge clk);
        check_flag("out_valid", out_valid, 1'b0);
    endtask

    initial begin
        logic [31:0] r;
        rstn      = 1'b0;
        cfg_valid = 1'b0;
        cfg_op    = dfe_pkg::OP_WRITE_TAP;
        cfg_index = '0;
        cfg_data  = '0;
        in_valid  = 1'b0;
        in_sample = '0;
        out_ready = 1'b1;
        lfsr      = LFSR_SEED;

        // coefficients and samples come from the LFSR before the model fills the table
        zero_taps = '0;
        get_bits(`DFE_SHIFT_W, r);
        zero_shift = r[`DFE_SHIFT_W-1:0];
        for (int k = 0; k < N_TAPS; k++) begin
            get_bits(`DFE_TAP_W, r);
            rand_taps[k] = r[`DFE_TAP_W-1:0];
        end
        get_bits(`DFE_SHIFT_W, r);
        rand_shift = r[`DFE_SHIFT_W-1:0];
        for (int n = 0; n < TABLE_LEN; n++) begin
            get_bits(`DFE_SAMPLE_W, r);
            sample_tab[n] = r[`DFE_SAMPLE_W-1:0];
        end
        fill_table(0, RAND_LEN, rand_taps, rand_shift);
        fill_table(RAND_LEN, ZERO_LEN, zero_taps, zero_shift);

        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        check_flag("loaded", loaded, 1'b0);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("cfg_ready", cfg_ready, 1'b1);
        check_flag("in_ready", in_ready, 1'b0);

        // three writes are not a full set, so the start is refused
        for (int k = 0; k < 3; k++) begin
            send_cmd(dfe_pkg::OP_WRITE_TAP, `DFE_IDX_W'(k), rand_taps[k]);
        end
        send_cmd(dfe_pkg::OP_START, '0, '0);
        expect_start_error();

        // the last tap and the shift complete the set
        send_cmd(dfe_pkg::OP_WRITE_TAP, `DFE_IDX_W'(3), rand_taps[3]);
        send_cmd(dfe_pkg::OP_WRITE_SHIFT, '0, dfe_pkg::tap_t'(rand_shift));
        send_cmd(dfe_pkg::OP_START, '0, '0);
        expect_start_ok();
        run_section(0, RAND_LEN);

        // clear drops out of RUN and wipes the taps and the history
        send_cmd(dfe_pkg::OP_CLEAR, '0, '0);
        @(negedge clk);
        check_flag("loaded", loaded, 1'b0);
        check_flag("cfg_ready", cfg_ready, 1'b0);
        check_flag("out_valid", out_valid, 1'b0);
        // the flush lasts one cycle and leaves the output register zeroed
        @(negedge clk);
        check_flag("cfg_ready", cfg_ready, 1'b1);
        check_eq("out_eq", out_eq, '0);
        check_decision("out_decision", out_decision, 1'b0);
        send_cmd(dfe_pkg::OP_START, '0, '0);
        expect_start_error();

        // zero taps reduce the DFE to a plain slicer, so any stale history shows up here
        load_coefs(zero_taps, zero_shift);
        send_cmd(dfe_pkg::OP_START, '0, '0);
        expect_start_ok();
        run_section(RAND_LEN, ZERO_LEN);

        $display("Simulation passed");
        $finish;
    end

endmodule

/* list.f */
+incdir+include
logic/dfe_pkg.sv
logic/dfe_coef_if.sv
logic/dfe_ctrl.sv
logic/tap_load_counter.sv
logic/tap_bank.sv
logic/dfe_datapath.sv
logic/dfe_top.sv
verif/dfe_tb.sv

/* Makefile */
# Verilator build and run of the DFE testbench

LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f list.f \
		--top-module dfe_tb -Mdir obj_dir -o dfe_sim

# the run passes only if the log holds the pass line
run: compile
	./obj_dir/dfe_sim | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
